// ==== hw/ll_pkg.sv ====
// Channel widths, strobe and marker locations, register map and reset values for the link layer
package ll_pkg;

  //////////////////////////////////////////////////////////////////////
  // Channel geometry

  localparam int CH_WIDTH       = 80;
  localparam int DATA_WIDTH     = 78;
  localparam int GEN2_DATA_BITS = 74;

  // DBI slot is the top bit of every group
  localparam int DBI_GROUP   = 20;
  localparam int DBI_PRESENT = 1;

  //////////////////////////////////////////////////////////////////////
  // Final strobe and marker locations on the channel word

  localparam int STROBE_GEN2_LOC   = 1;
  localparam int MARKER_GEN2_LOC   = 0;
  localparam int STROBE_GEN1_LOC   = 40;
  localparam int MARKER_GEN1_LOC   = 0;
  localparam int PERSISTENT_STROBE = 1;
  localparam int PERSISTENT_MARKER = 0;
  localparam int TX_REG_PHY        = 1;

  //////////////////////////////////////////////////////////////////////
  // Register map

  localparam int WB_ADDR_W = 4;
  localparam logic [WB_ADDR_W-1:0] REG_CTRL   = 4'h0;
  localparam logic [WB_ADDR_W-1:0] REG_STATUS = 4'h1;

  localparam int CTRL_W          = 4;
  localparam int CTRL_GEN2_BIT   = 0;
  localparam int CTRL_ONLINE_BIT = 1;
  localparam int CTRL_STB_BIT    = 2;
  localparam int CTRL_MRK_BIT    = 3;
  localparam int STAT_STB_BIT    = 0;
  localparam int STAT_MRK_BIT    = 1;

  // Gen1 and offline out of reset
  localparam logic [31:0] CTRL_RESET = 32'h0000_0000;

endpackage

// ==== hw/ll_tx_mux.sv ====
// Insertion of one strobe or marker bit into a channel word at a mode-selected location
`timescale 1ns/1ps

module ll_tx_mux #(
  parameter int PERSISTENT = 0,
  parameter int ENABLE     = 1,
  parameter int GEN2_LOC   = 0,
  parameter int GEN1_LOC   = 0
) (
  input  logic [ll_pkg::CH_WIDTH-1:0] data_in,
  output logic [ll_pkg::CH_WIDTH-1:0] data_out,
  input  logic                        tx_userbit,
  input  logic                        gen2_mode,
  input  logic                        online
);

  localparam logic [ll_pkg::CH_WIDTH-1:0] ONE = {{(ll_pkg::CH_WIDTH-1){1'b0}}, 1'b1};

  int unsigned                 loc;
  logic                        ins_bit;
  logic [ll_pkg::CH_WIDTH-1:0] slot_hot;
  logic [ll_pkg::CH_WIDTH-1:0] low_mask;

  // Both locations come from the package and are shared with the receive side
  if ((GEN2_LOC >= ll_pkg::CH_WIDTH) || (GEN1_LOC >= ll_pkg::CH_WIDTH)) begin : g_loc_check
    $error("Insertion location lies outside the channel word");
  end

  always_comb begin
    loc = gen2_mode ? GEN2_LOC : GEN1_LOC;

    // Offline the slot stays open but carries nothing
    if (!online) begin
      ins_bit = 1'b0;
    end else if (PERSISTENT != 0) begin
      ins_bit = 1'b1;
    end else begin
      ins_bit = tx_userbit;
    end

    slot_hot = ONE << loc;
    low_mask = slot_hot - ONE;

    // Low bits stay, upper bits move up one and the top input bit falls off
    if (ENABLE != 0) begin
      data_out = (data_in & low_mask)
               | ((data_in << 1) & ~low_mask & ~slot_hot)
               | (ins_bit ? slot_hot : '0);
    end else begin
      data_out = data_in;
    end
  end

endmodule

// ==== hw/ll_tx_concat_onechan.sv ====
// Transmit channel: DBI slot insertion, strobe and marker insertion, PHY output register
`timescale 1ns/1ps

module ll_tx_concat_onechan (
  input  logic                          clk_wr,
  input  logic                          rst_n,
  input  logic [ll_pkg::DATA_WIDTH-1:0] tx_data,
  output logic [ll_pkg::CH_WIDTH-1:0]   phy_tx,
  input  logic                          stb_userbit,
  input  logic                          mrk_userbit,
  input  logic                          gen2_mode,
  input  logic                          online
);

  // The marker goes in after the strobe, so a strobe above it is placed one lower
  localparam int STB_GEN2_ADJ = (ll_pkg::STROBE_GEN2_LOC > ll_pkg::MARKER_GEN2_LOC) ? 1 : 0;
  localparam int STB_GEN1_ADJ = (ll_pkg::STROBE_GEN1_LOC > ll_pkg::MARKER_GEN1_LOC) ? 1 : 0;

  localparam int N_GROUPS  = ll_pkg::CH_WIDTH / ll_pkg::DBI_GROUP;
  localparam int SLOT_BITS = ll_pkg::DBI_GROUP - 1;
  localparam int GEN2_W    = N_GROUPS * SLOT_BITS;

  logic [GEN2_W-1:0]           gen2_bits;
  logic [ll_pkg::CH_WIDTH-1:0] dbi_word;
  logic [ll_pkg::CH_WIDTH-1:0] post_dbi;
  logic [ll_pkg::CH_WIDTH-1:0] post_stb;
  logic [ll_pkg::CH_WIDTH-1:0] post_mrk;
  logic [ll_pkg::CH_WIDTH-1:0] phy_q;

  //////////////////////////////////////////////////////////////////////
  // DBI slots

  // Gen2 carries only the low data bits
  assign gen2_bits = GEN2_W'(tx_data[ll_pkg::GEN2_DATA_BITS-1:0]);

  always_comb begin
    dbi_word = '0;
    for (int g = 0; g < N_GROUPS; g++) begin
      dbi_word[g*ll_pkg::DBI_GROUP +: SLOT_BITS] = gen2_bits[g*SLOT_BITS +: SLOT_BITS];
    end
  end

  assign post_dbi = (gen2_mode && (ll_pkg::DBI_PRESENT != 0)) ? dbi_word
                                                               : ll_pkg::CH_WIDTH'(tx_data);

  //////////////////////////////////////////////////////////////////////
  // Strobe then marker

  ll_tx_mux #(
    .PERSISTENT (ll_pkg::PERSISTENT_STROBE),
    .ENABLE     (1),
    .GEN2_LOC   (ll_pkg::STROBE_GEN2_LOC - STB_GEN2_ADJ),
    .GEN1_LOC   (ll_pkg::STROBE_GEN1_LOC - STB_GEN1_ADJ)
  ) ll_tx_mux_istb (
    .data_in    (post_dbi),
    .data_out   (post_stb),
    .tx_userbit (stb_userbit),
    .gen2_mode  (gen2_mode),
    .online     (online)
  );

  ll_tx_mux #(
    .PERSISTENT (ll_pkg::PERSISTENT_MARKER),
    .ENABLE     (1),
    .GEN2_LOC   (ll_pkg::MARKER_GEN2_LOC),
    .GEN1_LOC   (ll_pkg::MARKER_GEN1_LOC)
  ) ll_tx_mux_imrk (
    .data_in    (post_stb),
    .data_out   (post_mrk),
    .tx_userbit (mrk_userbit),
    .gen2_mode  (gen2_mode),
    .online     (online)
  );

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      phy_q <= '0;
    end else begin
      phy_q <= post_mrk;
    end
  end

  assign phy_tx = (ll_pkg::TX_REG_PHY != 0) ? phy_q : post_mrk;

  // Offline words reach the PHY with empty strobe and marker positions
  if (ll_pkg::TX_REG_PHY != 0) begin : g_offline_chk
    a_offline_gen2: assert property (@(posedge clk_wr) disable iff (!rst_n)
      (!online && gen2_mode) |=>
        !phy_tx[ll_pkg::STROBE_GEN2_LOC] && !phy_tx[ll_pkg::MARKER_GEN2_LOC]);
    a_offline_gen1: assert property (@(posedge clk_wr) disable iff (!rst_n)
      (!online && !gen2_mode) |=>
        !phy_tx[ll_pkg::STROBE_GEN1_LOC] && !phy_tx[ll_pkg::MARKER_GEN1_LOC]);
  end

endmodule

// ==== hw/ll_rx_mux.sv ====
// Removal of one inserted bit from a channel word at a mode-selected location
`timescale 1ns/1ps

module ll_rx_mux #(
  parameter int GEN2_LOC = 0,
  parameter int GEN1_LOC = 0
) (
  input  logic [ll_pkg::CH_WIDTH-1:0] data_in,
  output logic [ll_pkg::CH_WIDTH-1:0] data_out,
  output logic                        rx_bit,
  input  logic                        gen2_mode
);

  localparam logic [ll_pkg::CH_WIDTH-1:0] ONE = {{(ll_pkg::CH_WIDTH-1){1'b0}}, 1'b1};

  int unsigned                 loc;
  logic [ll_pkg::CH_WIDTH-1:0] low_mask;

  always_comb begin
    loc      = gen2_mode ? GEN2_LOC : GEN1_LOC;
    low_mask = (ONE << loc) - ONE;
    rx_bit   = data_in[loc];

    // Everything above the slot drops by one, a zero fills the top
    data_out = (data_in & low_mask) | ((data_in >> 1) & ~low_mask);
  end

endmodule

// ==== hw/ll_rx_split_onechan.sv ====
// Receive channel: marker, strobe and DBI slot removal with the output register
`timescale 1ns/1ps

module ll_rx_split_onechan (
  input  logic                          clk_wr,
  input  logic                          rst_n,
  input  logic [ll_pkg::CH_WIDTH-1:0]   phy_rx,
  input  logic                          gen2_mode,
  output logic [ll_pkg::DATA_WIDTH-1:0] rx_data,
  output logic                          rx_stb,
  output logic                          rx_mrk
);

  // Once the marker is gone, a strobe that sat above it is one position lower
  localparam int STB_GEN2_ADJ = (ll_pkg::STROBE_GEN2_LOC > ll_pkg::MARKER_GEN2_LOC) ? 1 : 0;
  localparam int STB_GEN1_ADJ = (ll_pkg::STROBE_GEN1_LOC > ll_pkg::MARKER_GEN1_LOC) ? 1 : 0;

  localparam int N_GROUPS  = ll_pkg::CH_WIDTH / ll_pkg::DBI_GROUP;
  localparam int SLOT_BITS = ll_pkg::DBI_GROUP - 1;
  localparam int GEN2_W    = N_GROUPS * SLOT_BITS;

  logic [ll_pkg::CH_WIDTH-1:0]   post_mrk;
  logic [ll_pkg::CH_WIDTH-1:0]   post_stb;
  logic [GEN2_W-1:0]             gen2_bits;
  logic [ll_pkg::DATA_WIDTH-1:0] data_nxt;
  logic                          mrk_bit;
  logic                          stb_bit;

  ll_rx_mux #(
    .GEN2_LOC  (ll_pkg::MARKER_GEN2_LOC),
    .GEN1_LOC  (ll_pkg::MARKER_GEN1_LOC)
  ) ll_rx_mux_imrk (
    .data_in   (phy_rx),
    .data_out  (post_mrk),
    .rx_bit    (mrk_bit),
    .gen2_mode (gen2_mode)
  );

  ll_rx_mux #(
    .GEN2_LOC  (ll_pkg::STROBE_GEN2_LOC - STB_GEN2_ADJ),
    .GEN1_LOC  (ll_pkg::STROBE_GEN1_LOC - STB_GEN1_ADJ)
  ) ll_rx_mux_istb (
    .data_in   (post_mrk),
    .data_out  (post_stb),
    .rx_bit    (stb_bit),
    .gen2_mode (gen2_mode)
  );

  // Pack the 19 payload bits of every group back together
  always_comb begin
    for (int g = 0; g < N_GROUPS; g++) begin
      gen2_bits[g*SLOT_BITS +: SLOT_BITS] = post_stb[g*ll_pkg::DBI_GROUP +: SLOT_BITS];
    end
  end

  assign data_nxt = (gen2_mode && (ll_pkg::DBI_PRESENT != 0))
                  ? ll_pkg::DATA_WIDTH'(gen2_bits[ll_pkg::GEN2_DATA_BITS-1:0])
                  : post_stb[ll_pkg::DATA_WIDTH-1:0];

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_data <= '0;
      rx_stb  <= 1'b0;
      rx_mrk  <= 1'b0;
    end else begin
      rx_data <= data_nxt;
      rx_stb  <= stb_bit;
      rx_mrk  <= mrk_bit;
    end
  end

endmodule

// ==== hw/ll_ctrl_regs.sv ====
// Wishbone classic slave with the channel control register and the receive status register
`timescale 1ns/1ps

module ll_ctrl_regs (
  input  logic                         clk_wr,
  input  logic                         rst_n,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [ll_pkg::WB_ADDR_W-1:0] wb_adr,
  input  logic [31:0]                  wb_dat_w,
  output logic [31:0]                  wb_dat_r,
  output logic                         wb_ack,
  input  logic                         rx_stb,
  input  logic                         rx_mrk,
  output logic                         gen2_mode,
  output logic                         online,
  output logic                         stb_userbit,
  output logic                         mrk_userbit
);

  logic                      req;
  logic [ll_pkg::CTRL_W-1:0] ctrl_q;
  logic [31:0]               rd_nxt;

  // A new request is only taken while no ack is pending
  assign req = wb_cyc && wb_stb && !wb_ack;

  always_comb begin
    rd_nxt = '0;
    case (wb_adr)
      ll_pkg::REG_CTRL: rd_nxt[ll_pkg::CTRL_W-1:0] = ctrl_q;
      ll_pkg::REG_STATUS: begin
        rd_nxt[ll_pkg::STAT_STB_BIT] = rx_stb;
        rd_nxt[ll_pkg::STAT_MRK_BIT] = rx_mrk;
      end
      default: rd_nxt = '0;
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      ctrl_q <= ll_pkg::CTRL_RESET[ll_pkg::CTRL_W-1:0];
    end else begin
      wb_ack <= req;
      // Status and unmapped writes are acked and dropped
      if (req && wb_we && (wb_adr == ll_pkg::REG_CTRL)) begin
        ctrl_q <= wb_dat_w[ll_pkg::CTRL_W-1:0];
      end
    end
  end

  // Read data is sampled with the request and held through the ack cycle
  always_ff @(posedge clk_wr) begin
    if (req) begin
      wb_dat_r <= rd_nxt;
    end
  end

  assign gen2_mode   = ctrl_q[ll_pkg::CTRL_GEN2_BIT];
  assign online      = ctrl_q[ll_pkg::CTRL_ONLINE_BIT];
  assign stb_userbit = ctrl_q[ll_pkg::CTRL_STB_BIT];
  assign mrk_userbit = ctrl_q[ll_pkg::CTRL_MRK_BIT];

endmodule

// ==== hw/ll_chan_loopback_top.sv ====
// Top level with the control registers and one transmit channel looped into one receive channel
`timescale 1ns/1ps

module ll_chan_loopback_top (
  input  logic                          clk_wr,
  input  logic                          rst_n,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [ll_pkg::WB_ADDR_W-1:0]  wb_adr,
  input  logic [31:0]                   wb_dat_w,
  output logic [31:0]                   wb_dat_r,
  output logic                          wb_ack,
  input  logic [ll_pkg::DATA_WIDTH-1:0] tx_data,
  output logic [ll_pkg::CH_WIDTH-1:0]   phy_tx,
  output logic [ll_pkg::DATA_WIDTH-1:0] rx_data,
  output logic                          rx_stb,
  output logic                          rx_mrk
);

  logic gen2_mode;
  logic online;
  logic stb_userbit;
  logic mrk_userbit;

  ll_ctrl_regs u_ctrl_regs (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .rx_stb      (rx_stb),
    .rx_mrk      (rx_mrk),
    .gen2_mode   (gen2_mode),
    .online      (online),
    .stb_userbit (stb_userbit),
    .mrk_userbit (mrk_userbit)
  );

  ll_tx_concat_onechan u_tx_chan (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_data     (tx_data),
    .phy_tx      (phy_tx),
    .stb_userbit (stb_userbit),
    .mrk_userbit (mrk_userbit),
    .gen2_mode   (gen2_mode),
    .online      (online)
  );

  // The PHY side is looped straight back into the receive channel
  ll_rx_split_onechan u_rx_chan (
    .clk_wr    (clk_wr),
    .rst_n     (rst_n),
    .phy_rx    (phy_tx),
    .gen2_mode (gen2_mode),
    .rx_data   (rx_data),
    .rx_stb    (rx_stb),
    .rx_mrk    (rx_mrk)
  );

endmodule

// ==== dv/tb_ll_chan.sv ====
// Testbench for the looped-back channel: file stimulus, Wishbone tasks, reference model, checks
`timescale 1ns/1ps

module tb_ll_chan;

  localparam int MAX_LINES = 32;
  localparam int BURST_LEN = 12;

  logic                          clk_wr;
  logic                          rst_n;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [ll_pkg::WB_ADDR_W-1:0]  wb_adr;
  logic [31:0]                   wb_dat_w;
  logic [31:0]                   wb_dat_r;
  logic                          wb_ack;
  logic [ll_pkg::DATA_WIDTH-1:0] tx_data;
  logic [ll_pkg::CH_WIDTH-1:0]   phy_tx;
  logic [ll_pkg::DATA_WIDTH-1:0] rx_data;
  logic                          rx_stb;
  logic                          rx_mrk;

  // Stimulus table, one entry per data line of the file
  logic [3:0]                    st_ctrl     [MAX_LINES];
  logic [ll_pkg::DATA_WIDTH-1:0] st_data     [MAX_LINES];
  logic                          st_exp_stb  [MAX_LINES];
  logic                          st_exp_mrk  [MAX_LINES];
  logic [ll_pkg::DATA_WIDTH-1:0] st_exp_data [MAX_LINES];

  int          n_lines      = 0;
  int          errors       = 0;
  int          checks       = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          start_errors = 0;
  int          cycle_count  = 0;
  int          cycle_limit  = 100;
  logic [31:0] lfsr;

  ll_chan_loopback_top UUT (
    .clk_wr   (clk_wr),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .tx_data  (tx_data),
    .phy_tx   (phy_tx),
    .rx_data  (rx_data),
    .rx_stb   (rx_stb),
    .rx_mrk   (rx_mrk)
  );

  always #4 clk_wr = ~clk_wr;

  always @(posedge clk_wr) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not complete within %0d clock cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int count, output logic [ll_pkg::DATA_WIDTH-1:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[ll_pkg::DATA_WIDTH-2:0], lfsr[31]};
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic load_stim();
    int                            fd;
    int                            r;
    string                         line;
    logic [3:0]                    mode;
    logic [3:0]                    onl;
    logic [3:0]                    sub;
    logic [3:0]                    mub;
    logic [3:0]                    es;
    logic [3:0]                    em;
    logic [ll_pkg::DATA_WIDTH-1:0] d;
    logic [ll_pkg::DATA_WIDTH-1:0] ed;
    fd = $fopen("dv/ll_chan_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file dv/ll_chan_stim.txt");
    end else begin
      while (!$feof(fd) && (n_lines < MAX_LINES)) begin
        r = $fgets(line, fd);
        if ((r > 0) && (line.len() > 1) && (line[0] != "#")) begin
          r = $sscanf(line, "%h %h %h %h %h %h %h %h", mode, onl, sub, mub, d, es, em, ed);
          if (r == 8) begin
            st_ctrl[n_lines]     = {mub[0], sub[0], onl[0], mode[0]};
            st_data[n_lines]     = d;
            st_exp_stb[n_lines]  = es[0];
            st_exp_mrk[n_lines]  = em[0];
            st_exp_data[n_lines] = ed;
            n_lines++;
          end else begin
            errors++;
            $display("Malformed stimulus line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model of the transmit channel

  function automatic logic [ll_pkg::CH_WIDTH-1:0] insert_bit(
    input logic [ll_pkg::CH_WIDTH-1:0] w,
    input int                          loc,
    input logic                        b
  );
    logic [ll_pkg::CH_WIDTH-1:0] r;
    for (int i = 0; i < ll_pkg::CH_WIDTH; i++) begin
      if (i < loc) begin
        r[i] = w[i];
      end else if (i == loc) begin
        r[i] = b;
      end else begin
        r[i] = w[i-1];
      end
    end
    return r;
  endfunction

  task automatic build_phy(
    input  logic [3:0]                    ctrl,
    input  logic [ll_pkg::DATA_WIDTH-1:0] data,
    output logic [ll_pkg::CH_WIDTH-1:0]   word
  );
    logic                        gen2;
    logic                        onl;
    logic                        stb_val;
    logic                        mrk_val;
    int                          src;
    int                          stb_fin;
    int                          mrk_fin;
    logic [ll_pkg::CH_WIDTH-1:0] base;
    gen2 = ctrl[ll_pkg::CTRL_GEN2_BIT];
    onl  = ctrl[ll_pkg::CTRL_ONLINE_BIT];
    base = '0;
    src  = 0;
    // Gen2 skips the top bit of every 20-bit group
    for (int i = 0; i < ll_pkg::CH_WIDTH; i++) begin
      if (gen2 && (ll_pkg::DBI_PRESENT != 0)) begin
        if (((i % ll_pkg::DBI_GROUP) != ll_pkg::DBI_GROUP - 1) &&
            (src < ll_pkg::GEN2_DATA_BITS)) begin
          base[i] = data[src];
          src++;
        end
      end else if (i < ll_pkg::DATA_WIDTH) begin
        base[i] = data[i];
      end
    end
    stb_fin = gen2 ? ll_pkg::STROBE_GEN2_LOC : ll_pkg::STROBE_GEN1_LOC;
    mrk_fin = gen2 ? ll_pkg::MARKER_GEN2_LOC : ll_pkg::MARKER_GEN1_LOC;
    stb_val = onl && ((ll_pkg::PERSISTENT_STROBE != 0) || ctrl[ll_pkg::CTRL_STB_BIT]);
    mrk_val = onl && ((ll_pkg::PERSISTENT_MARKER != 0) || ctrl[ll_pkg::CTRL_MRK_BIT]);
    // The marker insertion moves a higher strobe up into its final place
    word = insert_bit(base, (stb_fin > mrk_fin) ? stb_fin - 1 : stb_fin, stb_val);
    word = insert_bit(word, mrk_fin, mrk_val);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and Wishbone access

  task automatic check_ch(input string name, input logic [ll_pkg::CH_WIDTH-1:0] got,
                          input logic [ll_pkg::CH_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic [ll_pkg::DATA_WIDTH-1:0] got,
                            input logic [ll_pkg::DATA_WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic wb_access(input logic we, input logic [ll_pkg::WB_ADDR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    logic [ll_pkg::DATA_WIDTH-1:0] gap;
    take_bits(1, gap);
    if (gap[0]) begin
      next_cycle();
    end
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    next_cycle();
    while (wb_ack !== 1'b1) begin
      next_cycle();
    end
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    next_cycle();
    checks++;
    if (wb_ack !== 1'b0) begin
      errors++;
      $display("wb_ack stayed high for a second cycle on address 0x%h", adr);
    end
  endtask

  task automatic test_start();
    start_errors = errors;
  endtask

  task automatic test_report(input string name);
    tests_run++;
    if (errors != start_errors) begin
      tests_failed++;
      $display("test %0d %s: failed", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin : main
    logic [31:0]                   rdat;
    logic [ll_pkg::CH_WIDTH-1:0]   exp_phy;
    logic [ll_pkg::DATA_WIDTH-1:0] burst [BURST_LEN];
    int                            stb_fin;
    int                            mrk_fin;
    clk_wr   = 1'b0;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    tx_data  = '0;
    lfsr     = 32'h41cf;
    load_stim();
    cycle_limit = n_lines * 20 + 100;
    repeat (3) @(posedge clk_wr);
    #1;
    rst_n = 1'b1;

    test_start();
    check_ch("phy_tx", phy_tx, '0);
    check_data("rx_data", rx_data, '0);
    check_bit("rx_stb", rx_stb, 1'b0);
    check_bit("rx_mrk", rx_mrk, 1'b0);
    check_bit("wb_ack", wb_ack, 1'b0);
    wb_access(1'b0, ll_pkg::REG_CTRL, '0, rdat);
    check_reg("REG_CTRL", rdat, ll_pkg::CTRL_RESET);
    test_report("reset values");

    test_start();
    wb_access(1'b1, ll_pkg::REG_STATUS, 32'hffff_ffff, rdat);
    // A status write must leave the control register untouched
    wb_access(1'b0, ll_pkg::REG_CTRL, '0, rdat);
    check_reg("REG_CTRL", rdat, ll_pkg::CTRL_RESET);
    wb_access(1'b0, ll_pkg::REG_STATUS, '0, rdat);
    check_reg("REG_STATUS", rdat, 32'h0);
    wb_access(1'b1, ll_pkg::REG_CTRL, 32'h0000_0005, rdat);
    wb_access(1'b0, ll_pkg::REG_CTRL, '0, rdat);
    check_reg("REG_CTRL", rdat, 32'h0000_0005);
    wb_access(1'b1, 4'h9, 32'h0000_000f, rdat);
    wb_access(1'b0, 4'h9, '0, rdat);
    check_reg("unmapped read", rdat, 32'h0);
    wb_access(1'b0, ll_pkg::REG_CTRL, '0, rdat);
    check_reg("REG_CTRL", rdat, 32'h0000_0005);
    test_report("register access");

    for (int n = 0; n < n_lines; n++) begin
      test_start();
      wb_access(1'b1, ll_pkg::REG_CTRL, 32'(st_ctrl[n]), rdat);
      tx_data = st_data[n];
      build_phy(st_ctrl[n], st_data[n], exp_phy);
      stb_fin = st_ctrl[n][0] ? ll_pkg::STROBE_GEN2_LOC : ll_pkg::STROBE_GEN1_LOC;
      mrk_fin = st_ctrl[n][0] ? ll_pkg::MARKER_GEN2_LOC : ll_pkg::MARKER_GEN1_LOC;
      next_cycle();
      check_ch("phy_tx", phy_tx, exp_phy);
      check_bit("phy_tx strobe slot", phy_tx[stb_fin], st_exp_stb[n]);
      check_bit("phy_tx marker slot", phy_tx[mrk_fin], st_exp_mrk[n]);
      next_cycle();
      check_data("rx_data", rx_data, st_exp_data[n]);
      check_bit("rx_stb", rx_stb, st_exp_stb[n]);
      check_bit("rx_mrk", rx_mrk, st_exp_mrk[n]);
      wb_access(1'b0, ll_pkg::REG_CTRL, '0, rdat);
      check_reg("REG_CTRL", rdat, 32'(st_ctrl[n]));
      wb_access(1'b0, ll_pkg::REG_STATUS, '0, rdat);
      // Status bit 1 is the marker and bit 0 the strobe
      check_reg("REG_STATUS", rdat, {30'd0, st_exp_mrk[n], st_exp_stb[n]});
      test_report($sformatf("stim line %0d", n + 1));
    end

    // Gen1 online with the marker user bit set, one new word every clock
    test_start();
    wb_access(1'b1, ll_pkg::REG_CTRL, 32'h0000_000a, rdat);
    for (int i = 0; i < BURST_LEN; i++) begin
      take_bits(ll_pkg::DATA_WIDTH, burst[i]);
    end
    for (int i = 0; i < BURST_LEN + 2; i++) begin
      if ((i >= 1) && (i <= BURST_LEN)) begin
        build_phy(4'ha, burst[i-1], exp_phy);
        check_ch("phy_tx", phy_tx, exp_phy);
      end
      if (i >= 2) begin
        check_data("rx_data", rx_data, burst[i-2]);
      end
      if (i < BURST_LEN) begin
        tx_data = burst[i];
      end
      next_cycle();
    end
    test_report("back-to-back burst");

    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hw/ll_pkg.sv
hw/ll_tx_mux.sv
hw/ll_tx_concat_onechan.sv
hw/ll_rx_mux.sv
hw/ll_rx_split_onechan.sv
hw/ll_ctrl_regs.sv
hw/ll_chan_loopback_top.sv
dv/tb_ll_chan.sv

// ==== dv/ll_chan_stim.txt ====
# Columns: gen2 online stb_userbit mrk_userbit tx_data
#          exp_rx_stb exp_rx_mrk exp_rx_data (data words are 78-bit hex)
0 1 0 1 00000000000000000000 1 1 00000000000000000000
0 1 0 0 3fffffffffffffffffff 1 0 3fffffffffffffffffff
0 1 1 1 2a5a5a5a5a5a5a5a5a5a 1 1 2a5a5a5a5a5a5a5a5a5a
0 1 1 0 15555555555555555555 1 0 15555555555555555555
0 1 0 1 0123456789abcdef0123 1 1 0123456789abcdef0123
0 1 1 1 20000000000000000001 1 1 20000000000000000001
1 1 0 1 00000000000000000000 1 1 00000000000000000000
1 1 0 0 3fffffffffffffffffff 1 0 03ffffffffffffffffff
1 1 1 1 2a5a5a5a5a5a5a5a5a5a 1 1 025a5a5a5a5a5a5a5a5a
1 1 0 0 15555555555555555555 1 0 01555555555555555555
1 1 1 1 0123456789abcdef0123 1 1 0123456789abcdef0123
1 1 0 1 3c0ffee0c0ffee0c0ffe 1 1 000ffee0c0ffee0c0ffe
1 1 1 0 00002000000000800000 1 0 00002000000000800000
0 0 1 1 3fffffffffffffffffff 0 0 3fffffffffffffffffff
1 0 1 1 3fffffffffffffffffff 0 0 03ffffffffffffffffff
0 0 0 1 2a5a5a5a5a5a5a5a5a5a 0 0 2a5a5a5a5a5a5a5a5a5a
1 0 1 0 15555555555555555555 0 0 01555555555555555555
0 1 0 0 00000000000000000001 1 0 00000000000000000001
1 1 0 1 00000000000000000001 1 1 00000000000000000001
